// ==== source/mcs51_pkg.sv ====
// MCS-51 shared widths, opcode codes, opcode union and datapath structs
`default_nettype none

package mcs51_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int REG_CNT = 8;
	localparam int REG_IDX_W = $clog2(REG_CNT);
	localparam int GROUP_W = DATA_W - REG_IDX_W;

	// ----------------------------------------------------------------------
	// Opcodes
	// ----------------------------------------------------------------------

	// Register group, matched on the upper five bits
	localparam logic [GROUP_W-1:0]
		GRP_MOV_A_RN = 5'b11101, GRP_MOV_RN_A = 5'b11111, GRP_MOV_RN_IMM = 5'b01111,
		GRP_ADD_A_RN = 5'b00101, GRP_ADDC_A_RN = 5'b00111, GRP_SUBB_A_RN = 5'b10011,
		GRP_ANL_A_RN = 5'b01011, GRP_ORL_A_RN = 5'b01001, GRP_XRL_A_RN = 5'b01101,
		GRP_INC_RN = 5'b00001, GRP_DEC_RN = 5'b00011, GRP_DJNZ_RN = 5'b11011;

	// Full-byte opcodes
	localparam logic [DATA_W-1:0]
		OP_MOV_A_IMM = 8'h74, OP_ADD_A_IMM = 8'h24, OP_ADDC_A_IMM = 8'h34,
		OP_SUBB_A_IMM = 8'h94, OP_ANL_A_IMM = 8'h54, OP_ORL_A_IMM = 8'h44,
		OP_XRL_A_IMM = 8'h64, OP_CLR_A = 8'hE4, OP_CPL_A = 8'hF4,
		OP_RL_A = 8'h23, OP_RR_A = 8'h03, OP_SWAP_A = 8'hC4,
		OP_INC_A = 8'h04, OP_DEC_A = 8'h14, OP_CLR_C = 8'hC3,
		OP_SETB_C = 8'hD3, OP_CPL_C = 8'hB3, OP_SJMP = 8'h80,
		OP_JZ = 8'h60, OP_JNZ = 8'h70, OP_JC = 8'h40,
		OP_JNC = 8'h50, OP_MOV_DIR_A = 8'hF5, OP_NOP = 8'h00;

	typedef struct packed {
		logic [GROUP_W-1:0] group;
		logic [REG_IDX_W-1:0] idx;
	} opcode_split_t;

	// One instruction byte, whole or as group code plus register index
	typedef union packed {
		logic [DATA_W-1:0] full;
		opcode_split_t split;
	} opcode_u;

	// ----------------------------------------------------------------------
	// Control and result types
	// ----------------------------------------------------------------------

	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_ADDC, ALU_SUBB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_CPL, ALU_RL, ALU_RR, ALU_SWAP, ALU_INC, ALU_DEC, ALU_CLR
	} alu_op_e;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_NONE} src_e;

	typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_REG} dst_e;

	typedef enum logic [2:0] {
		COND_NONE, COND_ALWAYS, COND_A_ZERO, COND_A_NZ,
		COND_CY, COND_NO_CY, COND_REG_NZ
	} cond_e;

	typedef enum logic [2:0] {CY_KEEP, CY_ALU, CY_CLR, CY_SET, CY_CPL} cy_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		src_e src;
		dst_e dst;
		logic [REG_IDX_W-1:0] reg_idx;
		logic two_byte;
		cond_e cond;
		cy_op_e cy_op;
		logic store;
	} ctrl_t;

	typedef struct packed {
		logic [DATA_W-1:0] result;
		logic cy;
	} exec_t;

endpackage

`default_nettype wire

// ==== source/mcs51_sequencer.sv ====
// MCS-51 phase machine, program counter, instruction and operand buffers, bus strobes
`timescale 1ns/1ps
`default_nettype none

module mcs51_sequencer import mcs51_pkg::*;
#(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
)
(
	input  logic clk,
	input  logic sys_rst_n,
	input  logic [DATA_W-1:0] mem_rdata_i,
	input  logic ready_i,
	input  ctrl_t ctrl_i,
	input  logic taken_i,
	input  logic [DATA_W-1:0] acc_i,
	output opcode_u opcode_o,
	output logic [DATA_W-1:0] operand_o,
	output logic exec_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [DATA_W-1:0] mem_wdata_o,
	output logic psen_n_o,
	output logic we_n_o
);

	typedef enum logic [1:0] {
		PH_FETCH,
		PH_OPER,
		PH_EXEC,
		PH_STORE
	} phase_e;

	phase_e phase_q;
	phase_e phase_d;
	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] target;
	opcode_u instr_q;
	logic [DATA_W-1:0] operand_q;
	logic psen_n_q;
	logic we_n_q;
	logic bus_done;

	// Bus phase closes on ready while a strobe is low
	assign bus_done = ready_i && !(psen_n_q && we_n_q);

	// Relative target taken from the address after the instruction
	assign target = pc_q + {{(ADDR_W-DATA_W){operand_q[DATA_W-1]}}, operand_q};

	always_comb
	begin
		phase_d = phase_q;
		case (phase_q)
			PH_FETCH:
				if (bus_done)
					phase_d = ctrl_i.two_byte ? PH_OPER : PH_EXEC;
			PH_OPER:
				if (bus_done)
					phase_d = PH_EXEC;
			PH_EXEC:
				phase_d = ctrl_i.store ? PH_STORE : PH_FETCH;
			default:
				if (bus_done)
					phase_d = PH_FETCH;
		endcase
	end

	// ----------------------------------------------------------------------
	// State, PC and strobes
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			phase_q <= PH_FETCH;
			pc_q <= RESET_PC;
			psen_n_q <= 1'b1;
			we_n_q <= 1'b1;
		end
		else
		begin
			phase_q <= phase_d;
			psen_n_q <= !(phase_d == PH_FETCH || phase_d == PH_OPER);
			we_n_q <= (phase_d != PH_STORE);
			if (bus_done && !psen_n_q)
				pc_q <= pc_q + 1'b1;
			else if (exec_o && taken_i)
				pc_q <= target;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus_done && phase_q == PH_FETCH)
			instr_q.full <= mem_rdata_i;
		if (bus_done && phase_q == PH_OPER)
			operand_q <= mem_rdata_i;
	end

	// Decode sees the byte on the bus during fetch
	// so the operand phase is known when fetch ends
	always_comb
	begin
		if (phase_q == PH_FETCH)
			opcode_o.full = mem_rdata_i;
		else
			opcode_o = instr_q;
	end

	assign mem_addr_o = (phase_q == PH_STORE) ? {{(ADDR_W-DATA_W){1'b0}}, operand_q} : pc_q;
	assign mem_wdata_o = acc_i;
	assign operand_o = operand_q;
	assign exec_o = (phase_q == PH_EXEC);
	assign psen_n_o = psen_n_q;
	assign we_n_o = we_n_q;

endmodule

`default_nettype wire

// ==== source/mcs51_decode.sv ====
// MCS-51 opcode decoder producing the control word
`timescale 1ns/1ps
`default_nettype none

module mcs51_decode import mcs51_pkg::*;
(
	input  opcode_u opcode_i,
	output ctrl_t ctrl_o
);

	// Special accumulator ops first
	// then the high nibble picks the op as in the 8051 opcode map
	function automatic alu_op_e alu_sel(input logic [DATA_W-1:0] code);
		case (code)
			OP_CLR_A: return ALU_CLR;
			OP_CPL_A: return ALU_CPL;
			OP_RL_A: return ALU_RL;
			OP_RR_A: return ALU_RR;
			OP_SWAP_A: return ALU_SWAP;
			default:
				case (code[7:4])
					4'h0: return ALU_INC;
					4'h1: return ALU_DEC;
					4'hD: return ALU_DEC;
					4'h2: return ALU_ADD;
					4'h3: return ALU_ADDC;
					4'h9: return ALU_SUBB;
					4'h5: return ALU_AND;
					4'h4: return ALU_OR;
					4'h6: return ALU_XOR;
					default: return ALU_PASS;
				endcase
		endcase
	endfunction

	always_comb
	begin
		ctrl_o.alu_op = alu_sel(opcode_i.full);
		ctrl_o.src = SRC_NONE;
		ctrl_o.dst = DST_NONE;
		ctrl_o.reg_idx = opcode_i.split.idx;
		ctrl_o.cond = COND_NONE;
		ctrl_o.cy_op = CY_KEEP;
		ctrl_o.store = 1'b0;
		case (opcode_i.split.group)
			GRP_MOV_A_RN, GRP_ADD_A_RN, GRP_ADDC_A_RN, GRP_SUBB_A_RN,
			GRP_ANL_A_RN, GRP_ORL_A_RN, GRP_XRL_A_RN:
			begin
				ctrl_o.src = SRC_REG;
				ctrl_o.dst = DST_ACC;
				ctrl_o.cy_op = CY_ALU;
			end
			GRP_MOV_RN_A, GRP_INC_RN, GRP_DEC_RN:
				ctrl_o.dst = DST_REG;
			GRP_MOV_RN_IMM:
			begin
				ctrl_o.src = SRC_IMM;
				ctrl_o.dst = DST_REG;
			end
			GRP_DJNZ_RN:
			begin
				ctrl_o.dst = DST_REG;
				ctrl_o.cond = COND_REG_NZ;
			end
			default:
				case (opcode_i.full)
					OP_MOV_A_IMM, OP_ADD_A_IMM, OP_ADDC_A_IMM, OP_SUBB_A_IMM,
					OP_ANL_A_IMM, OP_ORL_A_IMM, OP_XRL_A_IMM:
					begin
						ctrl_o.src = SRC_IMM;
						ctrl_o.dst = DST_ACC;
						ctrl_o.cy_op = CY_ALU;
					end
					OP_CLR_A, OP_CPL_A, OP_RL_A, OP_RR_A, OP_SWAP_A, OP_INC_A, OP_DEC_A:
						ctrl_o.dst = DST_ACC;
					OP_CLR_C: ctrl_o.cy_op = CY_CLR;
					OP_SETB_C: ctrl_o.cy_op = CY_SET;
					OP_CPL_C: ctrl_o.cy_op = CY_CPL;
					OP_SJMP: ctrl_o.cond = COND_ALWAYS;
					OP_JZ: ctrl_o.cond = COND_A_ZERO;
					OP_JNZ: ctrl_o.cond = COND_A_NZ;
					OP_JC: ctrl_o.cond = COND_CY;
					OP_JNC: ctrl_o.cond = COND_NO_CY;
					OP_MOV_DIR_A: ctrl_o.store = 1'b1;
					// NOP and unknown bytes
					default: ctrl_o.store = 1'b0;
				endcase
		endcase
		// Second byte holds an immediate, a branch offset or a direct address
		ctrl_o.two_byte = (ctrl_o.src == SRC_IMM) || (ctrl_o.cond != COND_NONE)
			|| ctrl_o.store;
	end

endmodule

`default_nettype wire

// ==== source/mcs51_execute.sv ====
// MCS-51 ALU with operand select, result byte and carry-out
`timescale 1ns/1ps
`default_nettype none

module mcs51_execute import mcs51_pkg::*;
(
	input  ctrl_t ctrl_i,
	input  logic [DATA_W-1:0] acc_i,
	input  logic [DATA_W-1:0] reg_i,
	input  logic [DATA_W-1:0] operand_i,
	input  logic cy_i,
	output exec_t exec_o
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;

	// Register destinations work on Rn, everything else on A
	assign op_a = (ctrl_i.dst == DST_REG) ? reg_i : acc_i;

	always_comb
	begin
		case (ctrl_i.src)
			SRC_REG: op_b = reg_i;
			SRC_IMM: op_b = operand_i;
			// No second operand, so moves take A
			default: op_b = acc_i;
		endcase
	end

	always_comb
	begin
		exec_o.cy = cy_i;
		case (ctrl_i.alu_op)
			ALU_ADD: {exec_o.cy, exec_o.result} = {1'b0, op_a} + {1'b0, op_b};
			ALU_ADDC: {exec_o.cy, exec_o.result} = {1'b0, op_a} + {1'b0, op_b} + cy_i;
			// Borrow lands in the ninth bit
			ALU_SUBB: {exec_o.cy, exec_o.result} = {1'b0, op_a} - {1'b0, op_b} - cy_i;
			ALU_AND: exec_o.result = op_a & op_b;
			ALU_OR: exec_o.result = op_a | op_b;
			ALU_XOR: exec_o.result = op_a ^ op_b;
			ALU_CPL: exec_o.result = ~op_a;
			ALU_RL: exec_o.result = {op_a[DATA_W-2:0], op_a[DATA_W-1]};
			ALU_RR: exec_o.result = {op_a[0], op_a[DATA_W-1:1]};
			ALU_SWAP: exec_o.result = {op_a[DATA_W/2-1:0], op_a[DATA_W-1:DATA_W/2]};
			ALU_INC: exec_o.result = op_a + 1'b1;
			ALU_DEC: exec_o.result = op_a - 1'b1;
			ALU_CLR: exec_o.result = '0;
			// Pass
			default: exec_o.result = op_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/mcs51_result.sv ====
// MCS-51 accumulator, register bank and carry write-back with branch decision
`timescale 1ns/1ps
`default_nettype none

module mcs51_result import mcs51_pkg::*;
(
	input  logic clk,
	input  logic sys_rst_n,
	input  ctrl_t ctrl_i,
	input  exec_t exec_i,
	input  logic exec_strobe_i,
	output logic [DATA_W-1:0] acc_o,
	output logic [DATA_W-1:0] reg_o,
	output logic cy_o,
	output logic taken_o
);

	logic [DATA_W-1:0] acc_q;
	logic [DATA_W-1:0] regs_q [REG_CNT];
	logic cy_q;

	// ----------------------------------------------------------------------
	// Write-back at the end of execute
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!sys_rst_n)
		begin
			acc_q <= '0;
			cy_q <= 1'b0;
			for (int i = 0; i < REG_CNT; i++)
				regs_q[i] <= '0;
		end
		else if (exec_strobe_i)
		begin
			case (ctrl_i.dst)
				DST_ACC: acc_q <= exec_i.result;
				DST_REG: regs_q[ctrl_i.reg_idx] <= exec_i.result;
				default: acc_q <= acc_q;
			endcase
			case (ctrl_i.cy_op)
				CY_ALU: cy_q <= exec_i.cy;
				CY_CLR: cy_q <= 1'b0;
				CY_SET: cy_q <= 1'b1;
				CY_CPL: cy_q <= !cy_q;
				default: cy_q <= cy_q;
			endcase
		end
	end

	// Conditions look at A and CY before this instruction writes them
	always_comb
	begin
		case (ctrl_i.cond)
			COND_ALWAYS: taken_o = 1'b1;
			COND_A_ZERO: taken_o = (acc_q == '0);
			COND_A_NZ: taken_o = (acc_q != '0);
			COND_CY: taken_o = cy_q;
			COND_NO_CY: taken_o = !cy_q;
			// DJNZ, decremented register
			COND_REG_NZ: taken_o = (exec_i.result != '0);
			default: taken_o = 1'b0;
		endcase
	end

	assign acc_o = acc_q;
	assign reg_o = regs_q[ctrl_i.reg_idx];
	assign cy_o = cy_q;

endmodule

`default_nettype wire

// ==== source/mcs51_core.sv ====
// MCS-51 core top level connecting sequencer, decoder, ALU and write-back
`timescale 1ns/1ps
`default_nettype none

module mcs51_core import mcs51_pkg::*;
#(
	parameter logic [ADDR_W-1:0] RESET_PC = '0
)
(
	input  logic clk,
	input  logic sys_rst_n,
	output logic [ADDR_W-1:0] mem_addr_o,
	input  logic [DATA_W-1:0] mem_rdata_i,
	output logic [DATA_W-1:0] mem_wdata_o,
	output logic psen_n_o,
	output logic we_n_o,
	input  logic ready_i
);

	opcode_u opcode;
	ctrl_t ctrl;
	exec_t exec_res;
	logic [DATA_W-1:0] operand;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] reg_val;
	logic exec_strobe;
	logic cy;
	logic taken;

	mcs51_sequencer #(
		.RESET_PC(RESET_PC)
	) mcs51_sequencer_i (
		.clk(clk),
		.sys_rst_n(sys_rst_n),
		.mem_rdata_i(mem_rdata_i),
		.ready_i(ready_i),
		.ctrl_i(ctrl),
		.taken_i(taken),
		.acc_i(acc),
		.opcode_o(opcode),
		.operand_o(operand),
		.exec_o(exec_strobe),
		.mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o),
		.psen_n_o(psen_n_o),
		.we_n_o(we_n_o)
	);

	mcs51_decode mcs51_decode_i (
		.opcode_i(opcode),
		.ctrl_o(ctrl)
	);

	mcs51_execute mcs51_execute_i (
		.ctrl_i(ctrl),
		.acc_i(acc),
		.reg_i(reg_val),
		.operand_i(operand),
		.cy_i(cy),
		.exec_o(exec_res)
	);

	mcs51_result mcs51_result_i (
		.clk(clk),
		.sys_rst_n(sys_rst_n),
		.ctrl_i(ctrl),
		.exec_i(exec_res),
		.exec_strobe_i(exec_strobe),
		.acc_o(acc),
		.reg_o(reg_val),
		.cy_o(cy),
		.taken_o(taken)
	);

endmodule

`default_nettype wire

// ==== sim/mcs51_clk_gen.sv ====
// Testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module mcs51_clk_gen
#(
	parameter real PERIOD_NS = 8.0
)
(
	output logic clk_o
);

	logic clk_q = 1'b0;

	always #(PERIOD_NS / 2.0) clk_q = !clk_q;

	assign clk_o = clk_q;

endmodule

`default_nettype wire

// ==== sim/mcs51_tb.sv ====
// MCS-51 core testbench with lazy random program memory, reference model and bus checks
`timescale 1ns/1ps
`default_nettype none

module mcs51_tb;

	localparam logic [15:0] RESET_PC = 16'h0100;
	localparam int INSTR_CNT = 400;
	localparam int TIMEOUT = 200;
	localparam int KIND_OPCODE = 0;
	localparam int KIND_OPERAND = 1;
	localparam int KIND_STORE = 2;

	// MOV A,Rn  MOV Rn,A  MOV Rn,#  ADD  ADDC  SUBB  ANL  ORL  XRL  INC  DEC  DJNZ
	localparam logic [12*8-1:0] GROUP_BASES = {
		8'hE8, 8'hF8, 8'h78, 8'h28, 8'h38, 8'h98,
		8'h58, 8'h48, 8'h68, 8'h08, 8'h18, 8'hD8};
	localparam logic [24*8-1:0] FULL_CODES = {
		8'h74, 8'h24, 8'h34, 8'h94, 8'h54, 8'h44, 8'h64, 8'hE4,
		8'hF4, 8'h23, 8'h03, 8'hC4, 8'h04, 8'h14, 8'hC3, 8'hD3,
		8'hB3, 8'h80, 8'h60, 8'h70, 8'h40, 8'h50, 8'hF5, 8'h00};

	logic clk;
	logic sys_rst_n = 1'b0;
	logic [15:0] mem_addr;
	logic [7:0] mem_rdata = 8'h00;
	logic [7:0] mem_wdata;
	logic psen_n;
	logic we_n;
	logic ready = 1'b0;

	logic [7:0] prog_mem [0:65535];
	bit filled [0:65535];

	// Reference model state
	logic [15:0] m_pc;
	logic [7:0] m_acc;
	logic m_cy;
	logic [7:0] m_regs [0:7];
	logic [7:0] m_op;
	logic [7:0] m_dir;
	int expect_kind;
	int instr_done;

	bit hold_chk;
	logic [15:0] held_addr;
	logic [7:0] held_wdata;
	logic held_psen;
	logic held_we;
	int rst_edges;
	int value_errs;
	int bus_errs;
	int timeouts;

	mcs51_clk_gen #(
		.PERIOD_NS(8.0)
	) mcs51_clk_gen_i (
		.clk_o(clk)
	);

	mcs51_core #(
		.RESET_PC(RESET_PC)
	) mcs51_core_i (
		.clk(clk),
		.sys_rst_n(sys_rst_n),
		.mem_addr_o(mem_addr),
		.mem_rdata_i(mem_rdata),
		.mem_wdata_o(mem_wdata),
		.psen_n_o(psen_n),
		.we_n_o(we_n),
		.ready_i(ready)
	);

	task automatic flag_mismatch(input string msg);
		value_errs++;
		$display("FAILED @%0t: %s", $time, msg);
	endtask

	function automatic logic [7:0] mem_read(input logic [15:0] a);
		if (filled[a])
			return prog_mem[a];
		return a[15:8] ^ a[7:0];
	endfunction

	function automatic bit two_byte_op(input logic [7:0] op);
		if (op[7:3] == 5'b01111 || op[7:3] == 5'b11011)
			return 1'b1;
		case (op)
			8'h74, 8'h24, 8'h34, 8'h94, 8'h54, 8'h44, 8'h64,
			8'h80, 8'h60, 8'h70, 8'h40, 8'h50, 8'hF5: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Only DJNZ jumps backward, so plain branches cannot trap the run
	function automatic logic [7:0] gen_operand(input logic [7:0] op);
		logic [7:0] v;
		if (op[7:3] == 5'b11011)
		begin
			v = 8'($urandom_range(16, 0));
			return v - 8'd8;
		end
		if (op == 8'h80 || op == 8'h60 || op == 8'h70 || op == 8'h40 || op == 8'h50)
			return 8'($urandom_range(8, 0));
		return 8'($urandom);
	endfunction

	function automatic logic [7:0] pick_opcode();
		int r;
		r = $urandom_range(39, 0);
		if (r < 12)
			return GROUP_BASES[r*8 +: 8] | 8'($urandom_range(7, 0));
		if (r < 36)
			return FULL_CODES[(r-12)*8 +: 8];
		// Extra stores, the only direct view of A
		return 8'hF5;
	endfunction

	task automatic place_instr(input logic [15:0] a);
		logic [15:0] nxt;
		nxt = a + 16'd1;
		if (!filled[a])
		begin
			prog_mem[a] = pick_opcode();
			filled[a] = 1'b1;
		end
		if (two_byte_op(prog_mem[a]) && !filled[nxt])
		begin
			prog_mem[nxt] = gen_operand(prog_mem[a]);
			filled[nxt] = 1'b1;
		end
	endtask

	task automatic alu_acc(input logic [3:0] nib, input logic [7:0] b);
		case (nib)
			4'h2: {m_cy, m_acc} = {1'b0, m_acc} + {1'b0, b};
			4'h3: {m_cy, m_acc} = {1'b0, m_acc} + {1'b0, b} + {8'h00, m_cy};
			4'h9: {m_cy, m_acc} = {1'b0, m_acc} - {1'b0, b} - {8'h00, m_cy};
			4'h5: m_acc = m_acc & b;
			4'h4: m_acc = m_acc | b;
			4'h6: m_acc = m_acc ^ b;
			// MOV A forms
			default: m_acc = b;
		endcase
	endtask

	// ------------------------------------------------------------------
	// Instruction-set model, m_pc already past the instruction
	// ------------------------------------------------------------------
	task automatic model_execute(input logic [7:0] op, input logic [7:0] opnd);
		logic [7:0] r;
		logic taken;
		r = m_regs[op[2:0]];
		taken = 1'b0;
		case (op[7:3])
			5'b11101, 5'b00101, 5'b00111, 5'b10011, 5'b01011, 5'b01001, 5'b01101:
				alu_acc(op[7:4], r);
			5'b11111: m_regs[op[2:0]] = m_acc;
			5'b01111: m_regs[op[2:0]] = opnd;
			5'b00001: m_regs[op[2:0]] = r + 8'd1;
			5'b00011: m_regs[op[2:0]] = r - 8'd1;
			5'b11011:
			begin
				m_regs[op[2:0]] = r - 8'd1;
				taken = (r != 8'd1);
			end
			default:
				case (op)
					8'h74, 8'h24, 8'h34, 8'h94, 8'h54, 8'h44, 8'h64: alu_acc(op[7:4], opnd);
					8'hE4: m_acc = 8'h00;
					8'hF4: m_acc = ~m_acc;
					8'h23: m_acc = {m_acc[6:0], m_acc[7]};
					8'h03: m_acc = {m_acc[0], m_acc[7:1]};
					8'hC4: m_acc = {m_acc[3:0], m_acc[7:4]};
					8'h04: m_acc = m_acc + 8'd1;
					8'h14: m_acc = m_acc - 8'd1;
					8'hC3: m_cy = 1'b0;
					8'hD3: m_cy = 1'b1;
					8'hB3: m_cy = !m_cy;
					8'h80: taken = 1'b1;
					8'h60: taken = (m_acc == 8'h00);
					8'h70: taken = (m_acc != 8'h00);
					8'h40: taken = m_cy;
					8'h50: taken = !m_cy;
					default: taken = 1'b0;
				endcase
		endcase
		if (taken)
			m_pc = m_pc + {{8{opnd[7]}}, opnd};
	endtask

	task automatic finish_instr(input logic [7:0] opnd);
		model_execute(m_op, opnd);
		place_instr(m_pc);
		if (m_op == 8'hF5)
		begin
			m_dir = opnd;
			expect_kind = KIND_STORE;
		end
		else
		begin
			expect_kind = KIND_OPCODE;
			instr_done++;
		end
	endtask

	// One completed bus phase moves the model by one byte or one store
	task automatic complete_phase();
		logic [7:0] byte_val;
		if (expect_kind == KIND_STORE)
		begin
			assert (!we_n) else
			begin
				bus_errs++;
				$display("A program fetch completed where a store was expected");
			end
			assert (mem_addr == {8'h00, m_dir}) else
				flag_mismatch($sformatf("store addr %h, expected %h", mem_addr, {8'h00, m_dir}));
			assert (mem_wdata == m_acc) else
				flag_mismatch($sformatf("store data %h, expected %h", mem_wdata, m_acc));
			expect_kind = KIND_OPCODE;
			instr_done++;
		end
		else
		begin
			assert (!psen_n) else
			begin
				bus_errs++;
				$display("A store completed where a program fetch was expected");
			end
			assert (mem_addr == m_pc) else
				flag_mismatch($sformatf("fetch addr %h, expected %h", mem_addr, m_pc));
			byte_val = mem_read(m_pc);
			m_pc = m_pc + 16'd1;
			if (expect_kind == KIND_OPERAND)
				finish_instr(byte_val);
			else
			begin
				m_op = byte_val;
				if (two_byte_op(m_op))
					expect_kind = KIND_OPERAND;
				else
					finish_instr(8'h00);
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Bus slave and per-cycle checks
	// ------------------------------------------------------------------
	always @(posedge clk)
	begin : bus_slave
		bit busy;
		if (!sys_rst_n)
		begin
			if (rst_edges > 0)
				assert (psen_n === 1'b1 && we_n === 1'b1) else
				begin
					bus_errs++;
					$display("A bus strobe was active during reset");
				end
			rst_edges++;
			ready <= 1'b0;
		end
		else
		begin
			busy = !psen_n || !we_n;
			assert (psen_n || we_n) else
			begin
				bus_errs++;
				$display("Program and data strobes were low in the same cycle");
			end
			if (hold_chk)
				assert (mem_addr == held_addr && mem_wdata == held_wdata
					&& psen_n == held_psen && we_n == held_we) else
					flag_mismatch($sformatf("bus moved in a stall, addr %h was %h",
						mem_addr, held_addr));
			hold_chk = busy && !ready;
			held_addr = mem_addr;
			held_wdata = mem_wdata;
			held_psen = psen_n;
			held_we = we_n;
			if (busy && ready)
				complete_phase();
			// Byte for the next cycle, at the held address or at the model PC
			if (busy && !ready)
				mem_rdata <= mem_read(mem_addr);
			else
				mem_rdata <= mem_read(m_pc);
			ready <= ($urandom_range(99, 0) < 70);
		end
	end

	task automatic wait_first_fetch(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT && !ok; n++)
		begin
			@(negedge clk);
			ok = !psen_n;
		end
		if (!ok)
		begin
			timeouts++;
			$display("Timeout: no program fetch started after reset");
		end
		else
			assert (mem_addr == RESET_PC) else
				flag_mismatch($sformatf("first fetch at %h, expected %h", mem_addr, RESET_PC));
	endtask

	task automatic wait_progress(output bit ok);
		int start;
		start = instr_done;
		ok = 1'b0;
		for (int n = 0; n < TIMEOUT && !ok; n++)
		begin
			@(negedge clk);
			ok = (instr_done != start);
		end
		if (!ok)
		begin
			timeouts++;
			$display("Timeout: no instruction completed within %0d cycles", TIMEOUT);
		end
	endtask

	initial
	begin
		int seed_val;
		bit alive;
		seed_val = $urandom(32'h34e3);
		m_pc = RESET_PC;
		m_acc = 8'h00;
		m_cy = 1'b0;
		for (int i = 0; i < 8; i++)
			m_regs[i] = 8'h00;
		expect_kind = KIND_OPCODE;
		place_instr(RESET_PC);
		repeat (4) @(posedge clk);
		sys_rst_n <= 1'b1;
		wait_first_fetch(alive);
		while (alive && instr_done < INSTR_CNT)
			wait_progress(alive);
		@(negedge clk);
		$display("Error counts: value %0d, bus %0d, timeout %0d", value_errs, bus_errs, timeouts);
		if (value_errs + bus_errs + timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
source/mcs51_pkg.sv
source/mcs51_sequencer.sv
source/mcs51_decode.sv
source/mcs51_execute.sv
source/mcs51_result.sv
source/mcs51_core.sv
sim/mcs51_clk_gen.sv
sim/mcs51_tb.sv

// ==== Bender.yml ====
package:
  name: mcs51_core

sources:
  - files:
      - source/mcs51_pkg.sv
      - source/mcs51_sequencer.sv
      - source/mcs51_decode.sv
      - source/mcs51_execute.sv
      - source/mcs51_result.sv
      - source/mcs51_core.sv

  - target: simulation
    files:
      - sim/mcs51_clk_gen.sv
      - sim/mcs51_tb.sv
